//--- Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+include
hw/dcache_addr_pkg.sv
hw/dcache_line_pkg.sv
hw/dcache_line_sram.sv
hw/dcache_line_state.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

//--- hw/dcache_addr_pkg.sv
`include "dcache_consts.svh"

package dcache_addr_pkg;

  typedef logic [`DC_TAG_W-1:0]   dc_tag_t;
  typedef logic [`DC_INDEX_W-1:0] dc_index_t;

  // Bits 31..19 are ignored by the cache
  typedef struct packed {
    logic [`DC_UNUSED_W-1:0] unused;
    dc_tag_t                 tag;
    dc_index_t               index;
    logic [`DC_OFFSET_W-1:0] offset;
  } dc_addr_fields_t;

  // Same request word, seen raw or split into cache fields
  typedef union packed {
    logic [`DC_ADDR_W-1:0] raw;
    dc_addr_fields_t       f;
  } dc_addr_u;

endpackage

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl
  import dcache_addr_pkg::*;
  import dcache_line_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Core side
  input  logic                  core_sel_i,
  input  logic                  core_we_i,
  input  logic [`DC_ADDR_W-1:0] core_addr_i,
  input  logic [`DC_DATA_W-1:0] core_wdata_i,
  input  logic [`DC_STRB_W-1:0] core_wmask_i,
  output logic [`DC_DATA_W-1:0] core_rdata_o,
  output logic                  core_stall_o,
  // Memory side
  output logic                  mem_valid_o,
  output logic                  mem_we_o,
  output logic [`DC_ADDR_W-1:0] mem_addr_o,
  output logic [`DC_DATA_W-1:0] mem_wdata_o,
  input  logic [`DC_DATA_W-1:0] mem_rdata_i,
  input  logic                  mem_ready_i,
  // Line memory
  output logic                  sram_wr_en_o,
  output dc_index_t             sram_wr_index_o,
  output logic [`DC_STRB_W-1:0] sram_wr_mask_o,
  output logic                  sram_wr_tag_en_o,
  output dc_line_t              sram_wr_line_o,
  output dc_index_t             sram_rd_index_o,
  input  dc_line_t              sram_rd_line_i,
  // Valid and dirty arrays
  output dc_index_t             st_index_o,
  output logic                  st_set_valid_o,
  output logic                  st_set_dirty_o,
  output logic                  st_clear_dirty_o,
  input  logic                  st_valid_i,
  input  logic                  st_dirty_i
);

  dc_state_e state_q;
  dc_state_e state_d;

  dc_addr_u req_addr;
  dc_addr_u wb_addr;
  dc_addr_u fill_addr;

  logic hit;
  logic victim_dirty;

  // Set between the memory read and the line write in UPDATE
  logic                  fill_q;
  logic [`DC_DATA_W-1:0] fill_data_q;

  logic                  mem_valid_q;
  logic                  mem_we_q;
  logic [`DC_ADDR_W-1:0] mem_addr_q;
  logic [`DC_DATA_W-1:0] mem_wdata_q;
  logic [`DC_DATA_W-1:0] rdata_q;

  // Upper address bits are not stored, so memory sees them as zero
  always_comb begin
    req_addr.raw = core_addr_i;

    wb_addr         = '0;
    wb_addr.f.tag   = sram_rd_line_i.tag;
    wb_addr.f.index = req_addr.f.index;

    fill_addr         = '0;
    fill_addr.f.tag   = req_addr.f.tag;
    fill_addr.f.index = req_addr.f.index;
  end

  // Entry read at acceptance is valid during LOOKUP
  assign hit          = st_valid_i && (sram_rd_line_i.tag == req_addr.f.tag);
  assign victim_dirty = st_valid_i && st_dirty_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (core_sel_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_d = core_we_i ? UPDATE : DONE;
        end else if (victim_dirty) begin
          state_d = WRITEBACK;
        end else begin
          state_d = FILL;
        end
      end
      WRITEBACK: begin
        if (mem_ready_i) begin
          state_d = FILL;
        end
      end
      FILL: begin
        if (mem_valid_q && mem_ready_i) begin
          state_d = UPDATE;
        end
      end
      UPDATE: begin
        // Write miss stays one more cycle to merge the store
        if (!(fill_q && core_we_i)) begin
          state_d = DONE;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      fill_q      <= 1'b0;
      mem_valid_q <= 1'b0;
      mem_we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      case (state_q)
        LOOKUP: begin
          if (!hit) begin
            mem_valid_q <= 1'b1;
            mem_we_q    <= victim_dirty;
          end
        end
        WRITEBACK: begin
          if (mem_ready_i) begin
            mem_valid_q <= 1'b0;
            mem_we_q    <= 1'b0;
          end
        end
        FILL: begin
          // Valid drops for a cycle after a write-back
          if (!mem_valid_q) begin
            mem_valid_q <= 1'b1;
          end else if (mem_ready_i) begin
            mem_valid_q <= 1'b0;
            fill_q      <= 1'b1;
          end
        end
        UPDATE: begin
          fill_q <= 1'b0;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LOOKUP) begin
      if (hit) begin
        rdata_q <= sram_rd_line_i.data;
      end
      mem_addr_q  <= victim_dirty ? wb_addr.raw : fill_addr.raw;
      mem_wdata_q <= sram_rd_line_i.data;
    end
    if (state_q == WRITEBACK && mem_ready_i) begin
      mem_addr_q <= fill_addr.raw;
    end
    if (state_q == FILL && mem_valid_q && mem_ready_i) begin
      fill_data_q <= mem_rdata_i;
      rdata_q     <= mem_rdata_i;
    end
  end

  assign core_rdata_o = rdata_q;
  assign core_stall_o = !(state_q == IDLE || state_q == DONE);

  assign mem_valid_o = mem_valid_q;
  assign mem_we_o    = mem_we_q;
  assign mem_addr_o  = mem_addr_q;
  assign mem_wdata_o = mem_wdata_q;

  // Fill writes the whole word and tag, store writes masked bytes only
  always_comb begin
    sram_wr_en_o        = (state_q == UPDATE);
    sram_wr_index_o     = req_addr.f.index;
    sram_wr_mask_o      = fill_q ? {`DC_STRB_W{1'b1}} : core_wmask_i;
    sram_wr_tag_en_o    = fill_q;
    sram_wr_line_o.tag  = req_addr.f.tag;
    sram_wr_line_o.data = fill_q ? fill_data_q : core_wdata_i;
  end

  assign sram_rd_index_o = req_addr.f.index;

  assign st_index_o       = req_addr.f.index;
  assign st_set_valid_o   = (state_q == UPDATE) && fill_q;
  assign st_clear_dirty_o = (state_q == UPDATE) && fill_q;
  assign st_set_dirty_o   = (state_q == UPDATE) && !fill_q;

  a_mem_valid_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o
  ) else $error("mem_valid_o dropped before mem_ready_i");

  a_mem_addr_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_ready_i |=> $stable(mem_addr_o)
  ) else $error("mem_addr_o changed while waiting for mem_ready_i");

endmodule

//--- hw/dcache_line_pkg.sv
`include "dcache_consts.svh"

package dcache_line_pkg;

  import dcache_addr_pkg::*;

  // One stored entry of the line memory, 40 bits
  typedef struct packed {
    dc_tag_t               tag;
    logic [`DC_DATA_W-1:0] data;
  } dc_line_t;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOOKUP    = 3'd1,
    WRITEBACK = 3'd2,
    FILL      = 3'd3,
    UPDATE    = 3'd4,
    DONE      = 3'd5
  } dc_state_e;

endpackage

//--- hw/dcache_line_sram.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_line_sram
  import dcache_addr_pkg::*;
  import dcache_line_pkg::*;
(
  input  logic                  clk_i,
  // Write port
  input  logic                  wr_en_i,
  input  dc_index_t             wr_index_i,
  input  logic [`DC_STRB_W-1:0] wr_mask_i,
  input  logic                  wr_tag_en_i,
  input  dc_line_t              wr_line_i,
  // Read port
  input  dc_index_t             rd_index_i,
  output dc_line_t              rd_line_o
);

  dc_line_t mem_q [`DC_LINES];

  // Tag and data bytes are written independently
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      if (wr_tag_en_i) begin
        mem_q[wr_index_i].tag <= wr_line_i.tag;
      end
      for (int b = 0; b < `DC_STRB_W; b++) begin
        if (wr_mask_i[b]) begin
          mem_q[wr_index_i].data[b*`DC_BYTE_W +: `DC_BYTE_W] <=
            wr_line_i.data[b*`DC_BYTE_W +: `DC_BYTE_W];
        end
      end
    end
  end

  // Registered read, returns old contents on a same-cycle write
  always_ff @(posedge clk_i) begin
    rd_line_o <= mem_q[rd_index_i];
  end

  a_wr_index_known: assert property (
    @(posedge clk_i) wr_en_i |-> !$isunknown(wr_index_i)
  ) else $error("line memory write with unknown index");

endmodule

//--- hw/dcache_line_state.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_line_state
  import dcache_addr_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  dc_index_t index_i,
  input  logic      set_valid_i,
  input  logic      set_dirty_i,
  input  logic      clear_dirty_i,
  output logic      valid_o,
  output logic      dirty_o
);

  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  assign valid_o = valid_q[index_i];
  assign dirty_o = dirty_q[index_i];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (set_valid_i) begin
        valid_q[index_i] <= 1'b1;
      end
      // A fill leaves the line clean, a store marks it dirty
      if (set_dirty_i) begin
        dirty_q[index_i] <= 1'b1;
      end else if (clear_dirty_i) begin
        dirty_q[index_i] <= 1'b0;
      end
    end
  end

  a_dirty_excl: assert property (
    @(posedge clk_i) disable iff (rst_i) !(set_dirty_i && clear_dirty_i)
  ) else $error("dirty bit set and cleared together");

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top
  import dcache_addr_pkg::*;
  import dcache_line_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  core_sel_i,
  input  logic                  core_we_i,
  input  logic [`DC_ADDR_W-1:0] core_addr_i,
  input  logic [`DC_DATA_W-1:0] core_wdata_i,
  input  logic [`DC_STRB_W-1:0] core_wmask_i,
  output logic [`DC_DATA_W-1:0] core_rdata_o,
  output logic                  core_stall_o,
  output logic                  mem_valid_o,
  output logic                  mem_we_o,
  output logic [`DC_ADDR_W-1:0] mem_addr_o,
  output logic [`DC_DATA_W-1:0] mem_wdata_o,
  input  logic [`DC_DATA_W-1:0] mem_rdata_i,
  input  logic                  mem_ready_i
);

  logic                  sram_wr_en;
  dc_index_t             sram_wr_index;
  logic [`DC_STRB_W-1:0] sram_wr_mask;
  logic                  sram_wr_tag_en;
  dc_line_t              sram_wr_line;
  dc_index_t             sram_rd_index;
  dc_line_t              sram_rd_line;

  dc_index_t st_index;
  logic      st_set_valid;
  logic      st_set_dirty;
  logic      st_clear_dirty;
  logic      st_valid;
  logic      st_dirty;

  dcache_ctrl ctrl_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .core_sel_i       (core_sel_i),
    .core_we_i        (core_we_i),
    .core_addr_i      (core_addr_i),
    .core_wdata_i     (core_wdata_i),
    .core_wmask_i     (core_wmask_i),
    .core_rdata_o     (core_rdata_o),
    .core_stall_o     (core_stall_o),
    .mem_valid_o      (mem_valid_o),
    .mem_we_o         (mem_we_o),
    .mem_addr_o       (mem_addr_o),
    .mem_wdata_o      (mem_wdata_o),
    .mem_rdata_i      (mem_rdata_i),
    .mem_ready_i      (mem_ready_i),
    .sram_wr_en_o     (sram_wr_en),
    .sram_wr_index_o  (sram_wr_index),
    .sram_wr_mask_o   (sram_wr_mask),
    .sram_wr_tag_en_o (sram_wr_tag_en),
    .sram_wr_line_o   (sram_wr_line),
    .sram_rd_index_o  (sram_rd_index),
    .sram_rd_line_i   (sram_rd_line),
    .st_index_o       (st_index),
    .st_set_valid_o   (st_set_valid),
    .st_set_dirty_o   (st_set_dirty),
    .st_clear_dirty_o (st_clear_dirty),
    .st_valid_i       (st_valid),
    .st_dirty_i       (st_dirty)
  );

  dcache_line_sram sram_i (
    .clk_i       (clk_i),
    .wr_en_i     (sram_wr_en),
    .wr_index_i  (sram_wr_index),
    .wr_mask_i   (sram_wr_mask),
    .wr_tag_en_i (sram_wr_tag_en),
    .wr_line_i   (sram_wr_line),
    .rd_index_i  (sram_rd_index),
    .rd_line_o   (sram_rd_line)
  );

  dcache_line_state state_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .index_i       (st_index),
    .set_valid_i   (st_set_valid),
    .set_dirty_i   (st_set_dirty),
    .clear_dirty_i (st_clear_dirty),
    .valid_o       (st_valid),
    .dirty_o       (st_dirty)
  );

endmodule

//--- include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Cache geometry, one word per line
`define DC_LINES     512
`define DC_INDEX_W   9
`define DC_TAG_W     8

// Request address split
`define DC_OFFSET_W  2
`define DC_UNUSED_W  13

// Core and memory port widths
`define DC_ADDR_W    32
`define DC_DATA_W    32
`define DC_STRB_W    4
`define DC_BYTE_W    8

`endif

//--- sim/dcache_mem_model.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_mem_model (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic                  we_i,
  input  logic [`DC_ADDR_W-1:0] addr_i,
  input  logic [`DC_DATA_W-1:0] wdata_i,
  output logic [`DC_DATA_W-1:0] rdata_o,
  output logic                  ready_o,
  output int                    rd_count_o,
  output int                    wr_count_o,
  output logic [`DC_ADDR_W-1:0] last_wr_addr_o,
  output logic [`DC_DATA_W-1:0] last_wr_data_o
);

  localparam int WORDS = 1 << (`DC_TAG_W + `DC_INDEX_W);

  logic [`DC_DATA_W-1:0] mem_q [WORDS];
  logic                  active_q;
  int                    wait_q;
  integer                seed = 95;

  // Halves of the byte address swapped, then scrambled
  initial begin
    logic [`DC_ADDR_W-1:0] a;
    for (int i = 0; i < WORDS; i++) begin
      a = `DC_ADDR_W'(i) << 2;
      mem_q[i] = {a[15:0], a[31:16]} ^ 32'hA5C3_5A3C;
    end
  end

  assign ready_o = active_q && (wait_q == 0);
  assign rdata_o = mem_q[addr_i[18:2]];

  always @(posedge clk_i) begin
    if (rst_i) begin
      active_q   <= 1'b0;
      wait_q     <= 0;
      rd_count_o <= 0;
      wr_count_o <= 0;
    end else if (valid_i && !active_q) begin
      active_q <= 1'b1;
      wait_q   <= int'($unsigned($random(seed)) % 4);
      if (we_i) begin
        wr_count_o     <= wr_count_o + 1;
        last_wr_addr_o <= addr_i;
        last_wr_data_o <= wdata_i;
        $display("  mem write addr=%h data=%h", addr_i, wdata_i);
      end else begin
        rd_count_o <= rd_count_o + 1;
      end
    end else if (active_q) begin
      if (wait_q == 0) begin
        active_q <= 1'b0;
        if (we_i) begin
          mem_q[addr_i[18:2]] <= wdata_i;
        end
      end else begin
        wait_q <= wait_q - 1;
      end
    end
  end

endmodule

//--- sim/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb
  import dcache_addr_pkg::*;
;

  localparam int NUM_REQ     = 67;
  localparam int WORST_MISS  = 12;
  localparam int CYCLE_LIMIT = NUM_REQ * WORST_MISS + 200;

  localparam logic [`DC_DATA_W-1:0] HIT_WDATA  = 32'hdead_beef;
  localparam logic [`DC_STRB_W-1:0] HIT_MASK   = 4'b0101;
  localparam logic [`DC_DATA_W-1:0] MISS_WDATA = 32'h1357_9bdf;
  localparam logic [`DC_STRB_W-1:0] MISS_MASK  = 4'b1001;

  logic                  clk_i;
  logic                  rst_i;
  logic                  core_sel;
  logic                  core_we;
  logic [`DC_ADDR_W-1:0] core_addr;
  logic [`DC_DATA_W-1:0] core_wdata;
  logic [`DC_STRB_W-1:0] core_wmask;
  logic [`DC_DATA_W-1:0] core_rdata;
  logic                  core_stall;
  logic                  mem_valid;
  logic                  mem_we;
  logic [`DC_ADDR_W-1:0] mem_addr;
  logic [`DC_DATA_W-1:0] mem_wdata;
  logic [`DC_DATA_W-1:0] mem_rdata;
  logic                  mem_ready;
  int                    mem_rd_count;
  int                    mem_wr_count;
  logic [`DC_ADDR_W-1:0] last_wr_addr;
  logic [`DC_DATA_W-1:0] last_wr_data;

  int cycles = 0;
  int checks = 0;
  int errors = 0;
  integer seed = 95;

  // Two tags sharing one index, plus a third line elsewhere
  dc_addr_u addr_a;
  dc_addr_u addr_b;
  dc_addr_u addr_c;

  // Reference model of cache plus memory
  logic                  m_valid [`DC_LINES];
  logic                  m_dirty [`DC_LINES];
  dc_tag_t               m_tag   [`DC_LINES];
  logic [`DC_DATA_W-1:0] m_data  [`DC_LINES];
  logic [`DC_DATA_W-1:0] ref_mem [int];
  int                    wb_addrs[$];
  int                    exp_rd = 0;
  int                    exp_wr = 0;

  dcache_top dut_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_sel_i   (core_sel),
    .core_we_i    (core_we),
    .core_addr_i  (core_addr),
    .core_wdata_i (core_wdata),
    .core_wmask_i (core_wmask),
    .core_rdata_o (core_rdata),
    .core_stall_o (core_stall),
    .mem_valid_o  (mem_valid),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .mem_ready_i  (mem_ready)
  );

  dcache_mem_model mem_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (mem_valid),
    .we_i           (mem_we),
    .addr_i         (mem_addr),
    .wdata_i        (mem_wdata),
    .rdata_o        (mem_rdata),
    .ready_o        (mem_ready),
    .rd_count_o     (mem_rd_count),
    .wr_count_o     (mem_wr_count),
    .last_wr_addr_o (last_wr_addr),
    .last_wr_data_o (last_wr_data)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: no completion within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [`DC_DATA_W-1:0] mem_pattern(input logic [`DC_ADDR_W-1:0] a);
    return {a[15:0], a[31:16]} ^ 32'hA5C3_5A3C;
  endfunction

  function automatic logic [`DC_DATA_W-1:0] merge_bytes(
    input logic [`DC_DATA_W-1:0] old_w,
    input logic [`DC_DATA_W-1:0] new_w,
    input logic [`DC_STRB_W-1:0] mask
  );
    logic [`DC_DATA_W-1:0] r;
    r = old_w;
    for (int b = 0; b < `DC_STRB_W; b++) begin
      if (mask[b]) begin
        r[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [`DC_DATA_W-1:0] ref_mem_read(input int a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return mem_pattern(a);
  endfunction

  function automatic dc_addr_u make_addr(input dc_tag_t tag, input dc_index_t index);
    dc_addr_u a;
    a         = '0;
    a.f.tag   = tag;
    a.f.index = index;
    return a;
  endfunction

  task automatic check_data(input string name, input logic [`DC_DATA_W-1:0] got,
                            input logic [`DC_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input dc_addr_u got, input dc_addr_u exp);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Applies write-back and allocate rules to the reference model
  task automatic model_access(input logic we, input dc_addr_u a,
                              input logic [`DC_DATA_W-1:0] wdata,
                              input logic [`DC_STRB_W-1:0] mask,
                              output logic [`DC_DATA_W-1:0] exp);
    dc_index_t i;
    dc_addr_u  victim;
    dc_addr_u  line_addr;
    i = a.f.index;
    if (!(m_valid[i] && m_tag[i] == a.f.tag)) begin
      if (m_valid[i] && m_dirty[i]) begin
        victim = make_addr(m_tag[i], i);
        ref_mem[int'(victim.raw)] = m_data[i];
        wb_addrs.push_back(int'(victim.raw));
        exp_wr++;
      end
      line_addr  = make_addr(a.f.tag, i);
      m_data[i]  = ref_mem_read(int'(line_addr.raw));
      m_tag[i]   = a.f.tag;
      m_valid[i] = 1'b1;
      m_dirty[i] = 1'b0;
      exp_rd++;
    end
    if (we) begin
      m_data[i]  = merge_bytes(m_data[i], wdata, mask);
      m_dirty[i] = 1'b1;
    end
    exp = m_data[i];
  endtask

  // Drives one request and waits for the first cycle with stall low
  task automatic access(input logic we, input dc_addr_u a,
                        input logic [`DC_DATA_W-1:0] wdata,
                        input logic [`DC_STRB_W-1:0] mask,
                        output logic [`DC_DATA_W-1:0] got,
                        output logic [`DC_DATA_W-1:0] exp);
    core_sel   = 1'b1;
    core_we    = we;
    core_addr  = a.raw;
    core_wdata = wdata;
    core_wmask = mask;
    @(posedge clk_i);
    @(negedge clk_i);
    if (!core_stall) begin
      errors++;
      $display("Request was not accepted, core_stall_o stayed low after select");
    end
    while (core_stall) begin
      @(negedge clk_i);
    end
    got      = core_rdata;
    core_sel = 1'b0;
    core_we  = 1'b0;
    @(negedge clk_i);
    model_access(we, a, wdata, mask, exp);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_read_miss();
    logic [`DC_DATA_W-1:0] got;
    logic [`DC_DATA_W-1:0] exp;
    int                    e0;
    int                    rd0;
    int                    wr0;
    e0  = errors;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    access(1'b0, addr_a, '0, '0, got, exp);
    check_data("core_rdata_o", got, mem_pattern(addr_a.raw));
    check_count("mem reads", mem_rd_count - rd0, 1);
    check_count("mem writes", mem_wr_count - wr0, 0);
    report_test("read miss", e0);
  endtask

  task automatic test_read_hit();
    logic [`DC_DATA_W-1:0] got;
    logic [`DC_DATA_W-1:0] exp;
    int                    e0;
    int                    rd0;
    int                    wr0;
    e0  = errors;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    access(1'b0, addr_a, '0, '0, got, exp);
    check_data("core_rdata_o", got, mem_pattern(addr_a.raw));
    check_count("mem reads", mem_rd_count - rd0, 0);
    check_count("mem writes", mem_wr_count - wr0, 0);
    report_test("read hit", e0);
  endtask

  task automatic test_write_hit();
    logic [`DC_DATA_W-1:0] got;
    logic [`DC_DATA_W-1:0] exp;
    int                    e0;
    int                    rd0;
    int                    wr0;
    e0  = errors;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    access(1'b1, addr_a, HIT_WDATA, HIT_MASK, got, exp);
    access(1'b0, addr_a, '0, '0, got, exp);
    check_data("core_rdata_o", got,
               merge_bytes(mem_pattern(addr_a.raw), HIT_WDATA, HIT_MASK));
    check_count("mem reads", mem_rd_count - rd0, 0);
    check_count("mem writes", mem_wr_count - wr0, 0);
    report_test("write hit", e0);
  endtask

  task automatic test_dirty_eviction();
    logic [`DC_DATA_W-1:0] got;
    logic [`DC_DATA_W-1:0] exp;
    dc_addr_u              wr_addr;
    int                    e0;
    int                    rd0;
    int                    wr0;
    e0  = errors;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    access(1'b0, addr_b, '0, '0, got, exp);
    wr_addr.raw = last_wr_addr;
    check_count("mem writes", mem_wr_count - wr0, 1);
    check_count("mem reads", mem_rd_count - rd0, 1);
    check_addr("mem_addr_o", wr_addr, addr_a);
    check_data("mem_wdata_o", last_wr_data,
               merge_bytes(mem_pattern(addr_a.raw), HIT_WDATA, HIT_MASK));
    check_data("core_rdata_o", got, mem_pattern(addr_b.raw));
    report_test("dirty eviction", e0);
  endtask

  task automatic test_write_miss();
    logic [`DC_DATA_W-1:0] got;
    logic [`DC_DATA_W-1:0] exp;
    int                    e0;
    int                    rd0;
    int                    wr0;
    e0  = errors;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    access(1'b1, addr_c, MISS_WDATA, MISS_MASK, got, exp);
    access(1'b0, addr_c, '0, '0, got, exp);
    check_data("core_rdata_o", got,
               merge_bytes(mem_pattern(addr_c.raw), MISS_WDATA, MISS_MASK));
    check_count("mem reads", mem_rd_count - rd0, 1);
    check_count("mem writes", mem_wr_count - wr0, 0);
    report_test("write miss allocate", e0);
  endtask

  task automatic test_random();
    dc_index_t             idx_set[3];
    dc_addr_u              a;
    logic                  we;
    logic [`DC_DATA_W-1:0] wdata;
    logic [`DC_STRB_W-1:0] mask;
    logic [`DC_DATA_W-1:0] got;
    logic [`DC_DATA_W-1:0] exp;
    int                    wa;
    int                    e0;
    e0 = errors;
    idx_set = '{9'h003, 9'h007, 9'h040};
    for (int n = 0; n < 60; n++) begin
      a = make_addr(dc_tag_t'(8'h20 + $unsigned($random(seed)) % 4),
                    idx_set[$unsigned($random(seed)) % 3]);
      we    = $random(seed) & 1;
      wdata = $random(seed);
      mask  = $random(seed);
      access(we, a, wdata, mask, got, exp);
      if (!we) begin
        check_data("core_rdata_o", got, exp);
      end
    end
    check_count("mem reads", mem_rd_count, exp_rd);
    check_count("mem writes", mem_wr_count, exp_wr);
    foreach (wb_addrs[k]) begin
      wa = wb_addrs[k];
      check_data("memory word", mem_i.mem_q[wa[18:2]], ref_mem[wa]);
    end
    report_test("random sequence", e0);
  endtask

  initial begin
    core_sel   = 1'b0;
    core_we    = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    core_wmask = '0;
    rst_i      = 1'b1;
    addr_a     = make_addr(8'h12, 9'h005);
    addr_b     = make_addr(8'h34, 9'h005);
    addr_c     = make_addr(8'h56, 9'h00a);
    for (int i = 0; i < `DC_LINES; i++) begin
      m_valid[i] = 1'b0;
      m_dirty[i] = 1'b0;
      m_tag[i]   = '0;
      m_data[i]  = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    test_read_miss();
    test_read_hit();
    test_write_hit();
    test_dirty_eviction();
    test_write_miss();
    test_random();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
